//--- all.f
hw/dma_pkg.sv
hw/dma_packet_buffer.sv
hw/dma_read_fifo.sv
hw/dma_target_ctrl.sv
hw/dma_target.sv
dv/tb_clock.sv
dv/dma_target_tb.sv

//--- dv/dma_target_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dma_target_tb;

  // Cycles any single wait may take
  localparam int WAIT_LIMIT = 2000;
  localparam int MEM_WORDS = 256;
  // Quiet cycles after the last response
  localparam int IDLE_CYCLES = 16;

  logic           clk;
  logic           rst;
  dma_pkg::flit_t noc_in_flit;
  logic           noc_in_valid;
  logic           noc_in_ready;
  dma_pkg::flit_t noc_out_flit;
  logic           noc_out_valid;
  logic           noc_out_ready = 1'b0;
  dma_pkg::wb_req_t wb_req;
  dma_pkg::wb_rsp_t wb_rsp = '0;

  // Stimulus and expected values from the vectors file
  dma_pkg::flit_t in_flits[$];
  dma_pkg::flit_t exp_flits[$];
  logic [31:0]    pre_addr[$];
  logic [31:0]    pre_data[$];
  logic [31:0]    chk_addr[$];
  logic [31:0]    chk_data[$];
  int             exp_xfers;

  // Memory model state
  logic [31:0] mem [MEM_WORDS];
  int          wait_left;
  int          xfer_count;
  // Response flits seen by the sink
  int          rx_count = 0;

  tb_clock tb_clock_i (
    .clk_o (clk)
  );

  dma_target dma_target_i (
    .clk             (clk),
    .rst             (rst),
    .noc_in_flit_i   (noc_in_flit),
    .noc_in_valid_i  (noc_in_valid),
    .noc_in_ready_o  (noc_in_ready),
    .noc_out_flit_o  (noc_out_flit),
    .noc_out_valid_o (noc_out_valid),
    .noc_out_ready_i (noc_out_ready),
    .wb_req_o        (wb_req),
    .wb_rsp_i        (wb_rsp)
  );

  ////////////////////////////////////////
  // Error reporting

  task automatic stop_with_failure();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_failure(input string why);
    $display("error at %0t: %s", $time, why);
    stop_with_failure();
  endtask

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  ////////////////////////////////////////
  // Vectors file

  task automatic load_vectors();
    int                fd;
    int                n;
    int                flit_pos;
    string             line;
    logic [7:0]        tag;
    logic [31:0]       a;
    logic [31:0]       b;
    dma_pkg::flit_t    f;
    dma_pkg::dma_hdr_t hdr;
    hdr = '0;
    flit_pos = 0;
    exp_xfers = 0;
    fd = $fopen("dv/dma_target_vectors.txt", "r");
    if (fd == 0) begin
      report_failure("the vectors file dv/dma_target_vectors.txt could not be opened");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%c %h %h", tag, a, b);
        // Comment lines carry a tag of their own and fall through
        if (n == 3) begin
          f = dma_pkg::flit_t'({a[1:0], b});
          case (tag)
            "M": begin
              pre_addr.push_back(a);
              pre_data.push_back(b);
            end
            "I": begin
              in_flits.push_back(f);
              // Bus transfers a request asks for
              if (f.ftype == dma_pkg::FLIT_HEADER) begin
                hdr = dma_pkg::dma_hdr_t'(f.content);
                flit_pos = 0;
                if (hdr.ptype == dma_pkg::PKT_R2L_REQ) begin
                  exp_xfers += int'(hdr.size);
                end
              end else begin
                flit_pos++;
                // Write payload starts after the address flit
                if (hdr.ptype == dma_pkg::PKT_L2R_REQ && flit_pos > 1) begin
                  exp_xfers++;
                end
              end
            end
            "O": exp_flits.push_back(f);
            "E": begin
              chk_addr.push_back(a);
              chk_data.push_back(b);
            end
            default: begin
            end
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // Wishbone memory

  // Acks 0 to 3 cycles after strobe, ack held for one cycle
  always @(negedge clk) begin
    wb_rsp.ack = 1'b0;
    if (rst) begin
      wait_left = -1;
      xfer_count = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] = 32'h6D00_0000 | (32'(i) << 2);
      end
      foreach (pre_addr[k]) begin
        mem[pre_addr[k][9:2]] = pre_data[k];
      end
    end else begin
      check_equal(64'(wb_req.cyc), 64'(wb_req.stb), "Wishbone cyc and stb differ");
      if (wb_req.stb) begin
        check_equal(64'(wb_req.adr[1:0]), 64'd0, "Wishbone address not word aligned");
        if (wait_left < 0) begin
          wait_left = int'($urandom_range(3, 0));
        end
        if (wait_left == 0) begin
          // Request is stable, so the transfer commits with the ack
          if (wb_req.we) begin
            mem[wb_req.adr[9:2]] = wb_req.dat;
          end
          wb_rsp.dat = mem[wb_req.adr[9:2]];
          wb_rsp.ack = 1'b1;
          xfer_count++;
          wait_left = -1;
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // NoC source and sink

  // Ready is random, a flit moves at the next rising edge
  always @(negedge clk) begin
    if (rst) begin
      noc_out_ready = 1'b0;
    end else begin
      noc_out_ready = ($urandom_range(3, 0) != 0);
      if (noc_out_valid && noc_out_ready) begin
        if (rx_count >= exp_flits.size()) begin
          report_failure("a response flit arrived when none was expected");
        end else begin
          check_equal(64'(noc_out_flit), 64'(exp_flits[rx_count]),
                      $sformatf("response flit %0d", rx_count));
          rx_count++;
        end
      end
    end
  end

  task automatic send_flit(input dma_pkg::flit_t f);
    int cycles;
    cycles = 0;
    repeat ($urandom_range(2, 0)) @(negedge clk);
    noc_in_flit = f;
    noc_in_valid = 1'b1;
    while (!noc_in_ready) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_failure("timeout waiting for noc_in_ready_o to accept a request flit");
      end
    end
    @(negedge clk);
    noc_in_valid = 1'b0;
  endtask

  ////////////////////////////////////////
  // Waits and final checks

  task automatic wait_responses();
    int cycles;
    cycles = 0;
    while (rx_count < exp_flits.size()) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_failure("timeout waiting for the expected response flits");
      end
    end
  endtask

  // Stray bus cycles or responses would show up here
  task automatic wait_bus_idle();
    int cycles;
    int idle;
    cycles = 0;
    idle = 0;
    while (idle < IDLE_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (wb_req.stb || noc_out_valid) begin
        idle = 0;
      end else begin
        idle++;
      end
      if (cycles > WAIT_LIMIT) begin
        report_failure("timeout waiting for the DUT to go idle");
      end
    end
  endtask

  task automatic check_reset_state();
    check_equal(64'(noc_out_valid), 64'd0, "noc_out_valid_o after reset");
    check_equal(64'(wb_req.cyc), 64'd0, "Wishbone cyc after reset");
    check_equal(64'(wb_req.stb), 64'd0, "Wishbone stb after reset");
    check_equal(64'(noc_in_ready), 64'd1, "noc_in_ready_o after reset");
  endtask

  task automatic check_memory();
    foreach (chk_addr[i]) begin
      check_equal(64'(mem[chk_addr[i][9:2]]), 64'(chk_data[i]),
                  $sformatf("memory word at %h", chk_addr[i]));
    end
  endtask

  initial begin
    void'($urandom(83));
    rst = 1'b1;
    noc_in_valid = 1'b0;
    noc_in_flit = '0;
    load_vectors();
    repeat (5) @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    foreach (in_flits[i]) begin
      send_flit(in_flits[i]);
    end
    wait_responses();
    wait_bus_idle();
    check_equal(64'(xfer_count), 64'(exp_xfers), "number of Wishbone transfers");
    check_memory();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/dma_target_vectors.txt
# Columns: tag, then two hex fields. M and E: byte address, word. I and O: flit type, content
# Flit types: 0 payload, 1 header, 2 last, 3 single

# Write of three words to 0x40 with request-last, id 1
I 1 1A38C003
I 0 00000040
I 0 A0000001
I 0 A0000002
I 2 A0000003
O 3 3A1C8000
E 40 A0000001
E 44 A0000002
E 48 A0000003

# Write without request-last, id 2, then one with it, id 3
I 1 1A390002
I 0 00000080
I 0 B0000001
I 2 B0000002
I 1 1A39C002
I 0 00000090
I 0 C0000001
I 2 C0000002
O 3 3A1D8000
E 80 B0000001
E 84 B0000002
E 90 C0000001
E 94 C0000002

# Packet of response type sent as a request, discarded
M C0 11110000
M C4 11110001
I 1 1A3E4002
I 0 000000C0
I 0 DEAD0001
I 2 DEAD0002
E C0 11110000
E C4 11110001

# Read of five words from 0x100, remote address 0x2000, id 2
M 100 55550000
M 104 55550001
M 108 55550002
M 10C 55550003
M 110 55550004
I 1 1A3B4005
I 0 00000100
I 2 00002000
O 1 3A1F4005
O 0 00002000
O 0 55550000
O 0 55550001
O 0 55550002
O 0 55550003
O 2 55550004

//--- dv/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk_o
);

  // 4 ns period, low for the first half
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

//--- hw/dma_packet_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module dma_packet_buffer (
  input  wire logic           clk,
  input  wire logic           rst,
  // Flits from the NoC
  input  wire dma_pkg::flit_t in_flit_i,
  input  wire logic           in_valid_i,
  output logic                in_ready_o,
  // Flits toward the control block once their packet is complete
  output dma_pkg::flit_t      out_flit_o,
  output logic                out_valid_o,
  input  wire logic           out_ready_i
);

  ////////////////////////////////////////
  // Storage and pointers

  dma_pkg::flit_t mem [dma_pkg::PACKET_DEPTH];

  // Pointers wrap on their own since the depth is a power of two
  logic [dma_pkg::PKT_PTR_WIDTH-1:0] wr_ptr;
  logic [dma_pkg::PKT_PTR_WIDTH-1:0] rd_ptr;
  // Flits stored and complete packets stored
  logic [dma_pkg::PKT_CNT_WIDTH-1:0] count;
  logic [dma_pkg::PKT_CNT_WIDTH-1:0] pkt_count;
  logic wr_en;
  logic rd_en;
  logic wr_last;
  logic rd_last;

  assign in_ready_o = count < dma_pkg::PKT_CNT_WIDTH'(dma_pkg::PACKET_DEPTH);
  assign out_valid_o = pkt_count != '0;
  assign out_flit_o = mem[rd_ptr];

  assign wr_en = in_valid_i && in_ready_o;
  assign rd_en = out_valid_o && out_ready_i;
  assign wr_last = dma_pkg::is_last_flit(in_flit_i.ftype);
  assign rd_last = dma_pkg::is_last_flit(out_flit_o.ftype);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_flit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      pkt_count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (!wr_en && rd_en) begin
        count <= count - 1'b1;
      end
      // Packet becomes visible the cycle after its closing flit lands
      if ((wr_en && wr_last) && !(rd_en && rd_last)) begin
        pkt_count <= pkt_count + 1'b1;
      end else if (!(wr_en && wr_last) && (rd_en && rd_last)) begin
        pkt_count <= pkt_count - 1'b1;
      end
    end
  end

  // A full buffer must hold a complete packet or it never drains
  a_full_has_packet: assert property (@(posedge clk) disable iff (rst)
    (count == dma_pkg::PKT_CNT_WIDTH'(dma_pkg::PACKET_DEPTH)) |-> (pkt_count != '0));
  // Packet count only offers flits that are really stored
  a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
    rd_en |-> (count != '0) && (pkt_count <= count));

endmodule

`default_nettype wire

//--- hw/dma_pkg.sv
`default_nettype none

package dma_pkg;

  ////////////////////////////////////////
  // Sizes and constants

  // Byte address and data word widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  // Two type bits on top of one data word
  localparam int FLIT_WIDTH = 34;
  localparam int FLIT_TYPE_WIDTH = 2;
  localparam int TILE_WIDTH = 5;
  localparam int SIZE_WIDTH = 14;
  // Id of this tile on the NoC
  localparam logic [TILE_WIDTH-1:0] TILE_ID = 5'd3;
  // Input buffer holds one maximum size packet
  localparam int PACKET_DEPTH = 16;
  localparam int PKT_PTR_WIDTH = $clog2(PACKET_DEPTH);
  localparam int PKT_CNT_WIDTH = $clog2(PACKET_DEPTH + 1);
  // Header and address flit leave the rest of a response for data
  localparam int MAX_READ_WORDS = PACKET_DEPTH - 2;
  localparam int READ_FIFO_DEPTH = 3;
  // Address step between consecutive words
  localparam int WORD_BYTES = 4;
  localparam logic [2:0] PACKET_CLASS_DMA = 3'd2;

  ////////////////////////////////////////
  // Encodings

  typedef enum logic [1:0] {
    FLIT_HEADER  = 2'b01,
    FLIT_PAYLOAD = 2'b00,
    FLIT_LAST    = 2'b10,
    FLIT_SINGLE  = 2'b11
  } flit_type_e;

  typedef enum logic [1:0] {
    PKT_L2R_REQ  = 2'b00,
    PKT_L2R_RESP = 2'b10,
    PKT_R2L_REQ  = 2'b01,
    PKT_R2L_RESP = 2'b11
  } packet_type_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_DISCARD,
    ST_L2R_ADDR,
    ST_L2R_DATA,
    ST_L2R_RESP,
    ST_R2L_LADDR,
    ST_R2L_RADDR,
    ST_R2L_HDR,
    ST_R2L_ADDR,
    ST_R2L_DATA
  } ctrl_state_e;

  ////////////////////////////////////////
  // Bundles

  typedef struct packed {
    flit_type_e                                ftype;
    logic [FLIT_WIDTH-FLIT_TYPE_WIDTH-1:0]     content;
  } flit_t;

  // Header flit content, destination in the top bits
  typedef struct packed {
    logic [TILE_WIDTH-1:0] dest;
    logic [2:0]            pclass;
    logic [TILE_WIDTH-1:0] src;
    packet_type_e          ptype;
    logic [1:0]            id;
    logic                  req_last;
    logic [SIZE_WIDTH-1:0] size;
  } dma_hdr_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] adr;
    logic [DATA_WIDTH-1:0] dat;
    logic                  we;
    logic                  cyc;
    logic                  stb;
  } wb_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] dat;
    logic                  ack;
  } wb_rsp_t;

  // LAST and SINGLE both close a packet
  function automatic logic is_last_flit(flit_type_e t);
    return (t == FLIT_LAST) || (t == FLIT_SINGLE);
  endfunction

endpackage

`default_nettype wire

//--- hw/dma_read_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module dma_read_fifo (
  input  wire logic                           clk,
  input  wire logic                           rst,
  // Write side, one word per read ack
  input  wire logic                           push_i,
  input  wire logic [dma_pkg::DATA_WIDTH-1:0] data_i,
  // Read side, one word per accepted data flit
  input  wire logic                           pop_i,
  output logic                                valid_o,
  output logic [dma_pkg::DATA_WIDTH-1:0]      data_o,
  output logic                                full_o
);

  ////////////////////////////////////////
  // Shift register

  logic [dma_pkg::READ_FIFO_DEPTH-1:0][dma_pkg::DATA_WIDTH-1:0] mem;
  logic [dma_pkg::READ_FIFO_DEPTH-1:0][dma_pkg::DATA_WIDTH-1:0] mem_nxt;
  // One-hot fill position, bit 0 set means empty, top bit set means full
  logic [dma_pkg::READ_FIFO_DEPTH:0] pos;
  // Entry that takes a pushed word, one lower when popping at once
  logic [dma_pkg::READ_FIFO_DEPTH-1:0] wr_sel;

  assign valid_o = !pos[0];
  assign full_o = pos[dma_pkg::READ_FIFO_DEPTH];
  // Head is always entry zero
  assign data_o = mem[0];
  assign wr_sel = pop_i ? pos[dma_pkg::READ_FIFO_DEPTH:1] : pos[dma_pkg::READ_FIFO_DEPTH-1:0];

  always_comb begin
    mem_nxt = mem;
    if (pop_i) begin
      for (int i = 0; i < dma_pkg::READ_FIFO_DEPTH - 1; i++) begin
        mem_nxt[i] = mem[i+1];
      end
    end
    for (int i = 0; i < dma_pkg::READ_FIFO_DEPTH; i++) begin
      if (push_i && wr_sel[i]) begin
        mem_nxt[i] = data_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    mem <= mem_nxt;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= {{dma_pkg::READ_FIFO_DEPTH{1'b0}}, 1'b1};
    end else if (push_i && !pop_i) begin
      pos <= pos << 1;
    end else if (!push_i && pop_i) begin
      pos <= pos >> 1;
    end
  end

  // Control block stalls Wishbone reads before the FIFO overflows
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    (push_i && full_o) |-> pop_i);
  // Data flits are only sent from a filled FIFO
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop_i |-> valid_o);

endmodule

`default_nettype wire

//--- hw/dma_target.sv
`timescale 1ns/10ps
`default_nettype none

module dma_target (
  input  wire logic             clk,
  input  wire logic             rst,
  // NoC request input
  input  wire dma_pkg::flit_t   noc_in_flit_i,
  input  wire logic             noc_in_valid_i,
  output logic                  noc_in_ready_o,
  // NoC response output
  output dma_pkg::flit_t        noc_out_flit_o,
  output logic                  noc_out_valid_o,
  input  wire logic             noc_out_ready_i,
  // Wishbone master port
  output dma_pkg::wb_req_t      wb_req_o,
  input  wire dma_pkg::wb_rsp_t wb_rsp_i
);

  ////////////////////////////////////////
  // Buffer to control block

  dma_pkg::flit_t buf_flit;
  logic           buf_valid;
  logic           buf_ready;

  // Control block to read FIFO
  logic                           fifo_push;
  logic                           fifo_pop;
  logic                           fifo_valid;
  logic [dma_pkg::DATA_WIDTH-1:0] fifo_data;
  logic                           fifo_full;

  // Whole packets only reach the FSM
  dma_packet_buffer dma_packet_buffer_i (
    .clk         (clk),
    .rst         (rst),
    .in_flit_i   (noc_in_flit_i),
    .in_valid_i  (noc_in_valid_i),
    .in_ready_o  (noc_in_ready_o),
    .out_flit_o  (buf_flit),
    .out_valid_o (buf_valid),
    .out_ready_i (buf_ready)
  );

  dma_target_ctrl dma_target_ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .req_flit_i   (buf_flit),
    .req_valid_i  (buf_valid),
    .req_ready_o  (buf_ready),
    .resp_flit_o  (noc_out_flit_o),
    .resp_valid_o (noc_out_valid_o),
    .resp_ready_i (noc_out_ready_i),
    .wb_req_o     (wb_req_o),
    .wb_rsp_i     (wb_rsp_i),
    .fifo_push_o  (fifo_push),
    .fifo_pop_o   (fifo_pop),
    .fifo_valid_i (fifo_valid),
    .fifo_data_i  (fifo_data),
    .fifo_full_i  (fifo_full)
  );

  // Read data waits here while the NoC stalls
  dma_read_fifo dma_read_fifo_i (
    .clk     (clk),
    .rst     (rst),
    .push_i  (fifo_push),
    .data_i  (wb_rsp_i.dat),
    .pop_i   (fifo_pop),
    .valid_o (fifo_valid),
    .data_o  (fifo_data),
    .full_o  (fifo_full)
  );

endmodule

`default_nettype wire

//--- hw/dma_target_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dma_target_ctrl (
  input  wire logic                           clk,
  input  wire logic                           rst,
  // Request flits from the packet buffer
  input  wire dma_pkg::flit_t                 req_flit_i,
  input  wire logic                           req_valid_i,
  output logic                                req_ready_o,
  // Response flits to the NoC
  output dma_pkg::flit_t                      resp_flit_o,
  output logic                                resp_valid_o,
  input  wire logic                           resp_ready_i,
  // Wishbone master
  output dma_pkg::wb_req_t                    wb_req_o,
  input  wire dma_pkg::wb_rsp_t               wb_rsp_i,
  // Read FIFO
  output logic                                fifo_push_o,
  output logic                                fifo_pop_o,
  input  wire logic                           fifo_valid_i,
  input  wire logic [dma_pkg::DATA_WIDTH-1:0] fifo_data_i,
  input  wire logic                           fifo_full_i
);

  dma_pkg::ctrl_state_e state;
  dma_pkg::ctrl_state_e state_nxt;

  // Request fields from the header
  logic [dma_pkg::TILE_WIDTH-1:0] src_tile;
  logic [1:0]                     pkt_id;
  logic [dma_pkg::SIZE_WIDTH-1:0] req_size;
  logic                           req_last;
  // Local word address and remote address of a read
  logic [dma_pkg::ADDR_WIDTH-1:0] laddr;
  logic [dma_pkg::ADDR_WIDTH-1:0] raddr;
  // Words acked on the bus and data flits sent
  logic [dma_pkg::SIZE_WIDTH-1:0] rd_count;
  logic [dma_pkg::SIZE_WIDTH-1:0] tx_count;

  dma_pkg::dma_hdr_t hdr_in;
  dma_pkg::dma_hdr_t hdr_out;
  logic req_fire;
  logic resp_fire;
  logic req_last_flit;
  logic size_bad;
  logic wr_go;
  logic rd_go;
  logic wb_ack;
  logic tx_last;

  assign hdr_in = dma_pkg::dma_hdr_t'(req_flit_i.content);
  assign req_fire = req_valid_i && req_ready_o;
  assign resp_fire = resp_valid_o && resp_ready_i;
  assign req_last_flit = dma_pkg::is_last_flit(req_flit_i.ftype);
  // Reads outside 1 to MAX_READ_WORDS words are not served
  assign size_bad = (hdr_in.size == '0) ||
                    (hdr_in.size > dma_pkg::SIZE_WIDTH'(dma_pkg::MAX_READ_WORDS));

  ////////////////////////////////////////
  // Wishbone master

  // One write per payload word, the buffer always holds the whole packet
  assign wr_go = (state == dma_pkg::ST_L2R_DATA) && req_valid_i;
  // Reads run from the response address flit on, paused by a full FIFO
  assign rd_go = ((state == dma_pkg::ST_R2L_ADDR) || (state == dma_pkg::ST_R2L_DATA)) &&
                 !fifo_full_i && (rd_count != req_size);
  assign wb_ack = wb_rsp_i.ack && wb_req_o.stb;

  always_comb begin
    wb_req_o.adr = laddr;
    wb_req_o.dat = wr_go ? req_flit_i.content : '0;
    wb_req_o.we = wr_go;
    // Classic cycles, cycle and strobe move together
    wb_req_o.cyc = wr_go || rd_go;
    wb_req_o.stb = wr_go || rd_go;
  end

  assign fifo_push_o = rd_go && wb_rsp_i.ack;
  assign fifo_pop_o = (state == dma_pkg::ST_R2L_DATA) && resp_fire;
  assign tx_last = tx_count == (req_size - 1'b1);

  ////////////////////////////////////////
  // Response flits

  always_comb begin
    hdr_out = '0;
    hdr_out.dest = src_tile;
    hdr_out.pclass = dma_pkg::PACKET_CLASS_DMA;
    hdr_out.src = dma_pkg::TILE_ID;
    hdr_out.id = pkt_id;
    resp_valid_o = 1'b0;
    resp_flit_o.ftype = dma_pkg::FLIT_PAYLOAD;
    resp_flit_o.content = '0;
    case (state)
      dma_pkg::ST_L2R_RESP: begin
        // Write acknowledge fits in one flit
        hdr_out.ptype = dma_pkg::PKT_L2R_RESP;
        resp_valid_o = 1'b1;
        resp_flit_o.ftype = dma_pkg::FLIT_SINGLE;
        resp_flit_o.content = hdr_out;
      end
      dma_pkg::ST_R2L_HDR: begin
        hdr_out.ptype = dma_pkg::PKT_R2L_RESP;
        hdr_out.req_last = 1'b1;
        hdr_out.size = req_size;
        resp_valid_o = 1'b1;
        resp_flit_o.ftype = dma_pkg::FLIT_HEADER;
        resp_flit_o.content = hdr_out;
      end
      dma_pkg::ST_R2L_ADDR: begin
        resp_valid_o = 1'b1;
        resp_flit_o.content = raddr;
      end
      dma_pkg::ST_R2L_DATA: begin
        // Data straight from the FIFO head
        resp_valid_o = fifo_valid_i;
        resp_flit_o.ftype = tx_last ? dma_pkg::FLIT_LAST : dma_pkg::FLIT_PAYLOAD;
        resp_flit_o.content = fifo_data_i;
      end
      default: begin
        resp_valid_o = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // FSM

  always_comb begin
    state_nxt = state;
    req_ready_o = 1'b0;
    case (state)
      dma_pkg::ST_IDLE: begin
        req_ready_o = 1'b1;
        // Header-only packets carry no request and are dropped here
        if (req_valid_i && !req_last_flit) begin
          if (hdr_in.ptype == dma_pkg::PKT_L2R_REQ) begin
            state_nxt = dma_pkg::ST_L2R_ADDR;
          end else if (hdr_in.ptype == dma_pkg::PKT_R2L_REQ && !size_bad) begin
            state_nxt = dma_pkg::ST_R2L_LADDR;
          end else begin
            state_nxt = dma_pkg::ST_DISCARD;
          end
        end
      end
      dma_pkg::ST_DISCARD: begin
        req_ready_o = 1'b1;
        if (req_valid_i && req_last_flit) begin
          state_nxt = dma_pkg::ST_IDLE;
        end
      end
      dma_pkg::ST_L2R_ADDR: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          if (!req_last_flit) begin
            state_nxt = dma_pkg::ST_L2R_DATA;
          end else begin
            state_nxt = req_last ? dma_pkg::ST_L2R_RESP : dma_pkg::ST_IDLE;
          end
        end
      end
      dma_pkg::ST_L2R_DATA: begin
        // Payload flit leaves the buffer with its ack
        req_ready_o = wb_ack;
        if (wb_ack && req_last_flit) begin
          state_nxt = req_last ? dma_pkg::ST_L2R_RESP : dma_pkg::ST_IDLE;
        end
      end
      dma_pkg::ST_L2R_RESP: begin
        if (resp_ready_i) begin
          state_nxt = dma_pkg::ST_IDLE;
        end
      end
      dma_pkg::ST_R2L_LADDR: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          state_nxt = dma_pkg::ST_R2L_RADDR;
        end
      end
      dma_pkg::ST_R2L_RADDR: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          state_nxt = dma_pkg::ST_R2L_HDR;
        end
      end
      dma_pkg::ST_R2L_HDR: begin
        if (resp_ready_i) begin
          state_nxt = dma_pkg::ST_R2L_ADDR;
        end
      end
      dma_pkg::ST_R2L_ADDR: begin
        if (resp_ready_i) begin
          state_nxt = dma_pkg::ST_R2L_DATA;
        end
      end
      dma_pkg::ST_R2L_DATA: begin
        if (resp_fire && tx_last) begin
          state_nxt = dma_pkg::ST_IDLE;
        end
      end
      default: begin
        state_nxt = dma_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dma_pkg::ST_IDLE;
      rd_count <= '0;
      tx_count <= '0;
    end else begin
      state <= state_nxt;
      if (state == dma_pkg::ST_IDLE) begin
        rd_count <= '0;
        tx_count <= '0;
      end else begin
        if (fifo_push_o) begin
          rd_count <= rd_count + 1'b1;
        end
        if (fifo_pop_o) begin
          tx_count <= tx_count + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == dma_pkg::ST_IDLE && req_fire) begin
      src_tile <= hdr_in.src;
      pkt_id <= hdr_in.id;
      req_size <= hdr_in.size;
      req_last <= hdr_in.req_last;
    end
    // Local address steps one word per ack, for writes and reads alike
    if ((state == dma_pkg::ST_L2R_ADDR || state == dma_pkg::ST_R2L_LADDR) && req_fire) begin
      laddr <= req_flit_i.content;
    end else if (wb_ack) begin
      laddr <= laddr + dma_pkg::WORD_BYTES;
    end
    if (state == dma_pkg::ST_R2L_RADDR && req_fire) begin
      raddr <= req_flit_i.content;
    end
  end

  // Wishbone request holds until the slave acks it
  a_wb_hold: assert property (@(posedge clk) disable iff (rst)
    (wb_req_o.stb && !wb_rsp_i.ack) |=> (wb_req_o.stb && $stable(wb_req_o)));
  // Offered response flit holds under back-pressure
  a_resp_hold: assert property (@(posedge clk) disable iff (rst)
    (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_flit_o)));

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the DMA target testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module dma_target_tb \
  -f all.f \
  -o dma_target_sim

sim_out=$(./obj_dir/dma_target_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qF "Test OK"; then
  exit 0
fi
exit 1
